// ==== design/ice_bus_pkg.sv ====
package ice_bus_pkg;

	// One UART character
	localparam int CHAR_W = 8;

	// Buffer words carry the character plus an end-of-frame flag on top
	localparam int BUF_W = 9;
	localparam int EOF_BIT = BUF_W - 1;

	// Ring buffer address width
	localparam int ADDR_W = 9;

	// Slave devices sharing the transmit path
	localparam int NUM_DEV = 2;

	// First character of a two-character NAK reply
	localparam logic [CHAR_W-1:0] NAK_CHAR = 8'h15;

	// Receive framer states
	localparam logic [2:0] RX_ST_IDLE = 3'd0;
	localparam logic [2:0] RX_ST_ID = 3'd1;
	localparam logic [2:0] RX_ST_LEN = 3'd2;
	localparam logic [2:0] RX_ST_PYLD = 3'd3;
	localparam logic [2:0] RX_ST_OVF = 3'd4;

	// Transmit reader states
	localparam logic [2:0] TX_ST_IDLE = 3'd0;
	localparam logic [2:0] TX_ST_SCAN = 3'd1;
	localparam logic [2:0] TX_ST_HEADER = 3'd2;
	localparam logic [2:0] TX_ST_LENGTH = 3'd3;
	localparam logic [2:0] TX_ST_PAYLOAD = 3'd4;

	// Output merger states
	localparam logic [1:0] MG_ST_IDLE = 2'd0;
	localparam logic [1:0] MG_ST_FRAME = 2'd1;
	localparam logic [1:0] MG_ST_NAK_CODE = 2'd2;
	localparam logic [1:0] MG_ST_NAK_ID = 2'd3;

endpackage

// ==== design/char_stream_if.sv ====
interface char_stream_if
	import ice_bus_pkg::*;
;

	// Character stream with valid/ready handshake
	logic              valid;
	logic              ready;
	logic [CHAR_W-1:0] data;
	// High on the final character of a frame
	logic              last;

	modport src (
		output valid,
		output data,
		output last,
		input  ready
	);

	modport snk (
		input  valid,
		input  data,
		input  last,
		output ready
	);

endinterface

// ==== design/priority_select.sv ====
module priority_select
	import ice_bus_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic [NUM_DEV-1:0] requests,
	input  logic               grant_release,
	output logic [NUM_DEV-1:0] grants,
	output logic               granted
);

	logic [NUM_DEV-1:0] lowest_req;

	// Two's complement trick isolates the lowest set request bit
	assign lowest_req = requests & (~requests + NUM_DEV'(1));

	assign granted = |grants;

	always_ff @(posedge clk) begin
		if (rst) begin
			grants <= '0;
		end else if (granted) begin
			// Grant stays put until the owner is done
			if (grant_release) begin
				grants <= '0;
			end
		end else begin
			grants <= lowest_req;
		end
	end

	// At most one device owns the bus
	assert property (@(posedge clk) disable iff (rst)
		$onehot0(grants));

endmodule

// ==== design/rx_frame_parser.sv ====
module rx_frame_parser
	import ice_bus_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [CHAR_W-1:0] rx_char,
	input  logic              rx_char_valid,
	input  logic              sl_overflow,
	output logic [CHAR_W-1:0] ma_addr,
	output logic              ma_data_valid,
	output logic              ma_frame_valid,
	output logic [CHAR_W-1:0] evt_id,
	output logic              nak_req,
	output logic [CHAR_W-1:0] nak_evt_id
);

	logic [2:0]        state;
	logic [2:0]        next_state;
	logic [CHAR_W-1:0] payload_len;
	logic [CHAR_W-1:0] byte_count;
	logic              record_addr;
	logic              record_evt_id;
	logic              load_len;
	logic              count_char;

	// NAK always carries the id of the frame that overflowed
	assign nak_evt_id = evt_id;

	always_comb begin
		next_state = state;
		record_addr = 1'b0;
		record_evt_id = 1'b0;
		load_len = 1'b0;
		count_char = 1'b0;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		nak_req = 1'b0;
		case (state)
			RX_ST_IDLE: begin
				// Address character opens the frame
				ma_frame_valid = rx_char_valid;
				record_addr = rx_char_valid;
				if (rx_char_valid) begin
					next_state = RX_ST_ID;
				end
			end
			RX_ST_ID: begin
				ma_frame_valid = rx_char_valid;
				ma_data_valid = rx_char_valid;
				record_evt_id = rx_char_valid;
				if (rx_char_valid) begin
					next_state = RX_ST_LEN;
				end
			end
			RX_ST_LEN: begin
				ma_frame_valid = rx_char_valid;
				ma_data_valid = rx_char_valid;
				load_len = rx_char_valid;
				if (rx_char_valid) begin
					// Zero length closes the frame right here
					next_state = (rx_char == '0) ? RX_ST_IDLE : RX_ST_PYLD;
				end
			end
			RX_ST_PYLD: begin
				ma_frame_valid = rx_char_valid;
				ma_data_valid = rx_char_valid;
				count_char = rx_char_valid;
				if (sl_overflow) begin
					next_state = RX_ST_OVF;
				end else if (rx_char_valid && (byte_count + 1'b1 == payload_len)) begin
					next_state = RX_ST_IDLE;
				end
			end
			RX_ST_OVF: begin
				nak_req = 1'b1;
				next_state = RX_ST_IDLE;
			end
			default: begin
				next_state = RX_ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RX_ST_IDLE;
			byte_count <= '0;
		end else begin
			state <= next_state;
			if (load_len) begin
				byte_count <= '0;
			end else if (count_char) begin
				byte_count <= byte_count + 1'b1;
			end
		end
	end

	// Frame header fields
	always_ff @(posedge clk) begin
		if (record_addr) begin
			ma_addr <= rx_char;
		end
		if (record_evt_id) begin
			evt_id <= rx_char;
		end
		if (load_len) begin
			payload_len <= rx_char;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		ma_data_valid |-> ma_frame_valid);

endmodule

// ==== design/tx_frame_reader.sv ====
module tx_frame_reader
	import ice_bus_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic [NUM_DEV-1:0] sl_arb_request,
	output logic [NUM_DEV-1:0] sl_arb_grant,
	output logic [ADDR_W-1:0]  sl_addr,
	input  logic [ADDR_W-1:0]  sl_tail,
	input  logic [BUF_W-1:0]   sl_data,
	output logic               sl_latch_tail,
	char_stream_if.src         out
);

	logic [2:0]        state;
	logic [ADDR_W-1:0] rd_offset;
	logic [ADDR_W-1:0] end_offset;
	logic [ADDR_W-1:0] frame_len;
	logic              granted;
	logic              xfer;

	// Frame-complete pulse hands the bus back to the arbiter
	priority_select arb_i (
		.clk           (clk),
		.rst           (rst),
		.requests      (sl_arb_request),
		.grant_release (sl_latch_tail),
		.grants        (sl_arb_grant),
		.granted       (granted)
	);

	assign sl_addr = sl_tail + rd_offset;

	// Payload is buffer words 2..k, so k-1 characters
	assign frame_len = end_offset - 1'b1;

	assign xfer = out.valid && out.ready;

	always_comb begin
		out.valid = 1'b0;
		out.data = sl_data[CHAR_W-1:0];
		out.last = 1'b0;
		case (state)
			TX_ST_HEADER: begin
				out.valid = 1'b1;
			end
			TX_ST_LENGTH: begin
				out.valid = 1'b1;
				out.data = frame_len[CHAR_W-1:0];
			end
			TX_ST_PAYLOAD: begin
				out.valid = 1'b1;
				out.last = (rd_offset == end_offset);
			end
			default: begin
				out.valid = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_ST_IDLE;
			rd_offset <= '0;
			sl_latch_tail <= 1'b0;
		end else begin
			sl_latch_tail <= xfer && out.last;
			case (state)
				TX_ST_IDLE: begin
					rd_offset <= '0;
					// Grant still shows the old owner while it is being released
					if (granted && !sl_latch_tail) begin
						state <= TX_ST_SCAN;
					end
				end
				TX_ST_SCAN: begin
					if (sl_data[EOF_BIT]) begin
						rd_offset <= '0;
						state <= TX_ST_HEADER;
					end else begin
						rd_offset <= rd_offset + 1'b1;
					end
				end
				TX_ST_HEADER: begin
					if (xfer) begin
						rd_offset <= rd_offset + 1'b1;
						if (rd_offset == ADDR_W'(1)) begin
							state <= TX_ST_LENGTH;
						end
					end
				end
				TX_ST_LENGTH: begin
					if (xfer) begin
						state <= TX_ST_PAYLOAD;
					end
				end
				TX_ST_PAYLOAD: begin
					if (xfer) begin
						rd_offset <= rd_offset + 1'b1;
						if (out.last) begin
							state <= TX_ST_IDLE;
						end
					end
				end
				default: begin
					state <= TX_ST_IDLE;
				end
			endcase
		end
	end

	// Offset of the end marker, found during the scan
	always_ff @(posedge clk) begin
		if (state == TX_ST_SCAN && sl_data[EOF_BIT]) begin
			end_offset <= rd_offset;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		(out.valid && !out.ready) |=> (out.valid && $stable(out.data) && $stable(out.last)));

	// Device buffers must hold at least address and id before the end marker
	assert property (@(posedge clk) disable iff (rst)
		(state == TX_ST_SCAN && sl_data[EOF_BIT]) |-> (rd_offset >= ADDR_W'(2)));

endmodule

// ==== design/tx_char_merge.sv ====
module tx_char_merge
	import ice_bus_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              nak_req,
	input  logic [CHAR_W-1:0] nak_evt_id,
	char_stream_if.snk        frames,
	output logic [CHAR_W-1:0] tx_char,
	output logic              tx_char_valid,
	input  logic              tx_char_ready
);

	logic [1:0]        state;
	logic              nak_pending;
	logic [CHAR_W-1:0] nak_id;
	logic              xfer;

	assign xfer = tx_char_valid && tx_char_ready;

	always_comb begin
		tx_char = frames.data;
		tx_char_valid = 1'b0;
		frames.ready = 1'b0;
		case (state)
			MG_ST_FRAME: begin
				tx_char_valid = frames.valid;
				frames.ready = tx_char_ready;
			end
			MG_ST_NAK_CODE: begin
				tx_char = NAK_CHAR;
				tx_char_valid = 1'b1;
			end
			MG_ST_NAK_ID: begin
				tx_char = nak_id;
				tx_char_valid = 1'b1;
			end
			default: begin
				tx_char_valid = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MG_ST_IDLE;
			nak_pending <= 1'b0;
		end else begin
			case (state)
				MG_ST_IDLE: begin
					// Pending NAK goes ahead of a waiting frame
					if (nak_pending) begin
						state <= MG_ST_NAK_CODE;
					end else if (frames.valid) begin
						state <= MG_ST_FRAME;
					end
				end
				MG_ST_FRAME: begin
					if (xfer && frames.last) begin
						state <= MG_ST_IDLE;
					end
				end
				MG_ST_NAK_CODE: begin
					if (xfer) begin
						state <= MG_ST_NAK_ID;
					end
				end
				MG_ST_NAK_ID: begin
					if (xfer) begin
						state <= MG_ST_IDLE;
						nak_pending <= 1'b0;
					end
				end
				default: begin
					state <= MG_ST_IDLE;
				end
			endcase
			if (nak_req) begin
				nak_pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (nak_req) begin
			nak_id <= nak_evt_id;
		end
	end

	// A second request would overwrite the one still waiting
	assert property (@(posedge clk) disable iff (rst)
		nak_req |-> !nak_pending);

endmodule

// ==== design/ice_bus_controller.sv ====
module ice_bus_controller
	import ice_bus_pkg::*;
(
	input  logic               clk,
	input  logic               rst,

	// UART side
	input  logic [CHAR_W-1:0]  rx_char,
	input  logic               rx_char_valid,
	output logic [CHAR_W-1:0]  tx_char,
	output logic               tx_char_valid,
	input  logic               tx_char_ready,

	// Master bus
	output logic [CHAR_W-1:0]  ma_data,
	output logic [CHAR_W-1:0]  ma_addr,
	output logic               ma_data_valid,
	output logic               ma_frame_valid,
	output logic [CHAR_W-1:0]  evt_id,
	input  logic               sl_overflow,

	// Slave buffers and arbitration
	output logic [ADDR_W-1:0]  sl_addr,
	input  logic [ADDR_W-1:0]  sl_tail,
	output logic               sl_latch_tail,
	input  logic [BUF_W-1:0]   sl_data,
	input  logic [NUM_DEV-1:0] sl_arb_request,
	output logic [NUM_DEV-1:0] sl_arb_grant
);

	logic              nak_req;
	logic [CHAR_W-1:0] nak_evt_id;

	char_stream_if frame_chars ();

	// Master bus data is the raw receive stream
	assign ma_data = rx_char;

	rx_frame_parser rx_i (
		.clk            (clk),
		.rst            (rst),
		.rx_char        (rx_char),
		.rx_char_valid  (rx_char_valid),
		.sl_overflow    (sl_overflow),
		.ma_addr        (ma_addr),
		.ma_data_valid  (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.evt_id         (evt_id),
		.nak_req        (nak_req),
		.nak_evt_id     (nak_evt_id)
	);

	tx_frame_reader reader_i (
		.clk            (clk),
		.rst            (rst),
		.sl_arb_request (sl_arb_request),
		.sl_arb_grant   (sl_arb_grant),
		.sl_addr        (sl_addr),
		.sl_tail        (sl_tail),
		.sl_data        (sl_data),
		.sl_latch_tail  (sl_latch_tail),
		.out            (frame_chars.src)
	);

	tx_char_merge merge_i (
		.clk           (clk),
		.rst           (rst),
		.nak_req       (nak_req),
		.nak_evt_id    (nak_evt_id),
		.frames        (frame_chars.snk),
		.tx_char       (tx_char),
		.tx_char_valid (tx_char_valid),
		.tx_char_ready (tx_char_ready)
	);

endmodule

// ==== dv/ice_bus_tb.sv ====
module ice_bus_tb
	import ice_bus_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS = 5;
	localparam logic [31:0] LFSR_SEED = 32'h82c98852;
	localparam int BUF_DEPTH = 2 ** ADDR_W;

	logic               clk = 1'b0;
	logic               rst;
	logic [CHAR_W-1:0]  rx_char;
	logic               rx_char_valid;
	logic [CHAR_W-1:0]  tx_char;
	logic               tx_char_valid;
	logic               tx_char_ready = 1'b0;
	logic [CHAR_W-1:0]  ma_data;
	logic [CHAR_W-1:0]  ma_addr;
	logic               ma_data_valid;
	logic               ma_frame_valid;
	logic [CHAR_W-1:0]  evt_id;
	logic               sl_overflow;
	logic [ADDR_W-1:0]  sl_addr;
	logic [ADDR_W-1:0]  sl_tail;
	logic               sl_latch_tail;
	logic [BUF_W-1:0]   sl_data;
	logic [NUM_DEV-1:0] sl_arb_request = '0;
	logic [NUM_DEV-1:0] sl_arb_grant;

	// Device buffer model
	logic [BUF_W-1:0]  dev_buf [NUM_DEV][BUF_DEPTH];
	logic [ADDR_W-1:0] head [NUM_DEV];
	logic [ADDR_W-1:0] tail [NUM_DEV] = '{default: '0};
	int                posted [NUM_DEV];
	int                retired [NUM_DEV] = '{default: 0};
	int                done_dev = 0;
	int                latch_count = 0;
	int                retire_count = 0;
	int                data_count = 0;
	int                frame_count = 0;
	logic [31:0]       lfsr = LFSR_SEED;

	logic [CHAR_W-1:0] tx_q [$];
	logic [CHAR_W-1:0] exp_q [$];

	ice_bus_controller dut_i (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	assign sl_tail = sl_arb_grant[1] ? tail[1] : tail[0];
	assign sl_data = sl_arb_grant[1] ? dev_buf[1][sl_addr] : dev_buf[0][sl_addr];

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end else begin
			return s >> 1;
		end
	endfunction

	// Words from the device tail up to and including the end marker
	function automatic int frame_words(input int dev);
		logic [ADDR_W-1:0] a;
		int n;
		a = tail[dev];
		n = 1;
		while (!dev_buf[dev][a][EOF_BIT] && n < BUF_DEPTH) begin
			a = a + ADDR_W'(1);
			n++;
		end
		return n;
	endfunction

	// One LFSR bit per cycle decides the UART ready
	always @(posedge clk) begin
		#2;
		tx_char_ready = lfsr[0];
		lfsr = lfsr_step(lfsr);
	end

	// Tail moves past the finished frame, then requests follow the pending frames
	always @(posedge clk) begin
		#2;
		if (latch_count != retire_count) begin
			tail[done_dev] = tail[done_dev] + ADDR_W'(frame_words(done_dev));
			retired[done_dev]++;
			retire_count++;
		end
		sl_arb_request = {posted[1] != retired[1], posted[0] != retired[0]};
	end

	always @(negedge clk) begin
		if (tx_char_valid && tx_char_ready) begin
			tx_q.push_back(tx_char);
		end
		if (ma_data_valid) begin
			data_count++;
		end
		if (ma_frame_valid) begin
			frame_count++;
		end
		if (sl_latch_tail) begin
			done_dev = sl_arb_grant[1] ? 1 : 0;
			latch_count++;
		end
	end

	initial begin
		#(NUM_TESTS * 2000 * CLK_PERIOD);
		$display("Checks failed");
		$fatal(1, "Timeout: the tests did not finish in time");
	end

	task automatic stop_with_failure();
		$display("Checks failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_char(input string what, input logic [CHAR_W-1:0] got,
		input logic [CHAR_W-1:0] want);
		if (got !== want) begin
			$display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, want);
			stop_with_failure();
		end
	endtask

	task automatic check_addr(input string what, input logic [ADDR_W-1:0] got,
		input logic [ADDR_W-1:0] want);
		if (got !== want) begin
			$display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, want);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic want);
		if (got !== want) begin
			$display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, want);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string what, input int got, input int want);
		if (got != want) begin
			$display("ERROR at %0d ns: %s is %0d, expected %0d", $time, what, got, want);
			stop_with_failure();
		end
	endtask

	task automatic send_rx(input logic [CHAR_W-1:0] c, input logic ovf);
		@(posedge clk);
		#2;
		rx_char = c;
		rx_char_valid = 1'b1;
		sl_overflow = ovf;
		@(posedge clk);
		#2;
		rx_char_valid = 1'b0;
		sl_overflow = 1'b0;
	endtask

	// Writes a frame of k+1 words at the head and queues the characters it should produce
	task automatic load_frame(input int dev, input logic [CHAR_W-1:0] addr_c,
		input logic [CHAR_W-1:0] id_c, input int k);
		logic [CHAR_W-1:0] c;
		int i;
		for (i = 0; i <= k; i++) begin
			if (i == 0) begin
				c = addr_c;
			end else if (i == 1) begin
				c = id_c;
			end else begin
				c = id_c + CHAR_W'(i * 7);
			end
			dev_buf[dev][head[dev]] = {i == k, c};
			if (i == 2) begin
				exp_q.push_back(CHAR_W'(k - 1));
			end
			exp_q.push_back(c);
			head[dev] = head[dev] + ADDR_W'(1);
		end
	endtask

	task automatic wait_grant(input int dev, input logic [ADDR_W-1:0] start);
		@(negedge clk);
		while (!sl_arb_grant[dev]) begin
			@(negedge clk);
		end
		check_addr($sformatf("sl_addr when device %0d is granted", dev), sl_addr, start);
	endtask

	task automatic expect_stream(input string what);
		logic [CHAR_W-1:0] want;
		int n;
		n = 0;
		while (tx_q.size() < exp_q.size()) begin
			@(negedge clk);
		end
		while (exp_q.size() > 0) begin
			want = exp_q.pop_front();
			check_char($sformatf("%s, tx_char %0d", what, n), tx_q.pop_front(), want);
			n++;
		end
	endtask

	task automatic wait_retired();
		while (posted[0] != retired[0] || posted[1] != retired[1] || sl_arb_grant != '0) begin
			@(negedge clk);
		end
	endtask

	task automatic test_reset_state();
		#10;
		check_flag("tx_char_valid after reset", tx_char_valid, 1'b0);
		check_flag("ma_frame_valid after reset", ma_frame_valid, 1'b0);
		check_flag("ma_data_valid after reset", ma_data_valid, 1'b0);
		check_flag("sl_latch_tail after reset", sl_latch_tail, 1'b0);
		check_flag("any sl_arb_grant after reset", |sl_arb_grant, 1'b0);
	endtask

	task automatic test_rx_frame();
		int base;
		int frame_base;
		base = data_count;
		frame_base = frame_count;
		send_rx(8'h4c, 1'b0);
		send_rx(8'h91, 1'b0);
		send_rx(8'd3, 1'b0);
		send_rx(8'ha0, 1'b0);
		send_rx(8'ha1, 1'b0);
		send_rx(8'ha2, 1'b0);
		check_count("ma_data_valid strobes in a 3-char frame", data_count - base, 5);
		check_count("ma_frame_valid strobes in a 3-char frame", frame_count - frame_base, 6);
		check_char("ma_addr", ma_addr, 8'h4c);
		check_char("evt_id", evt_id, 8'h91);
		// Next character must open a new frame
		@(posedge clk);
		#2;
		rx_char = 8'h37;
		rx_char_valid = 1'b1;
		#10;
		check_flag("ma_frame_valid on the next address", ma_frame_valid, 1'b1);
		check_flag("ma_data_valid on the next address", ma_data_valid, 1'b0);
		check_char("ma_data on the next address", ma_data, 8'h37);
		@(posedge clk);
		#2;
		rx_char_valid = 1'b0;
		check_char("ma_addr of the next frame", ma_addr, 8'h37);
		send_rx(8'h92, 1'b0);
		send_rx(8'd0, 1'b0);
	endtask

	task automatic test_single_frame();
		logic [ADDR_W-1:0] start;
		int base;
		check_count("stray characters on tx_char", tx_q.size(), 0);
		start = head[0];
		base = latch_count;
		load_frame(0, 8'h10, 8'h5a, 4);
		@(negedge clk);
		posted[0]++;
		wait_grant(0, start);
		expect_stream("device 0 frame");
		wait_retired();
		check_count("sl_latch_tail pulses for one frame", latch_count - base, 1);
	endtask

	task automatic test_two_devices();
		logic [ADDR_W-1:0] start0;
		logic [ADDR_W-1:0] start1;
		int base;
		check_count("stray characters on tx_char", tx_q.size(), 0);
		start0 = head[0];
		start1 = head[1];
		base = latch_count;
		load_frame(0, 8'h21, 8'h62, 3);
		load_frame(1, 8'h22, 8'h63, 5);
		@(negedge clk);
		posted[0]++;
		posted[1]++;
		wait_grant(0, start0);
		wait_grant(1, start1);
		expect_stream("device 0 then device 1");
		wait_retired();
		check_count("sl_latch_tail pulses for two frames", latch_count - base, 2);
	endtask

	task automatic test_nak_after_frame();
		logic [CHAR_W-1:0] nak_id;
		nak_id = 8'he3;
		check_count("stray characters on tx_char", tx_q.size(), 0);
		load_frame(0, 8'h30, 8'h71, 10);
		@(negedge clk);
		posted[0]++;
		// Overflow lands while the device frame is on its way out
		while (tx_q.size() == 0) begin
			@(negedge clk);
		end
		send_rx(8'h5e, 1'b0);
		send_rx(nak_id, 1'b0);
		send_rx(8'd4, 1'b0);
		send_rx(8'hc0, 1'b1);
		exp_q.push_back(NAK_CHAR);
		exp_q.push_back(nak_id);
		expect_stream("frame then NAK");
		wait_retired();
	endtask

	initial begin
		rst = 1'b1;
		rx_char = '0;
		rx_char_valid = 1'b0;
		sl_overflow = 1'b0;
		for (int d = 0; d < NUM_DEV; d++) begin
			head[d] = '0;
			posted[d] = 0;
			for (int a = 0; a < BUF_DEPTH; a++) begin
				dev_buf[d][a] = {1'b0, CHAR_W'(a) ^ CHAR_W'(a >> 8) ^ CHAR_W'(8'h5a + d)};
			end
		end
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		test_reset_state();
		test_rx_frame();
		test_single_frame();
		test_two_devices();
		test_nak_after_frame();
		$display("All checks passed");
		$finish;
	end

endmodule

// ==== files.f ====
design/ice_bus_pkg.sv
design/char_stream_if.sv
design/priority_select.sv
design/rx_frame_parser.sv
design/tx_frame_reader.sv
design/tx_char_merge.sv
design/ice_bus_controller.sv
dv/ice_bus_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = -Wall -Wno-fatal --timing --assert
TOP       = ice_bus_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
